//--- hw/start_screen_pkg.sv
`default_nettype none

package start_screen_pkg;

    localparam int COORD_W = 11;
    localparam int RGB_W   = 12;

    // Visible area
    localparam int H_PIXELS = 1024;
    localparam int V_PIXELS = 768;

    localparam logic [RGB_W-1:0] FRAME_COLOR = 12'hfff;
    localparam logic [RGB_W-1:0] BLACK       = 12'h000;

    localparam int N_TITLE   = 33;
    localparam int N_OUTLINE = 4;
    localparam int N_LABEL   = 18;

    // Each entry is top, bottom, left, right; all bounds exclusive
    localparam logic [COORD_W-1:0] TITLE_RECTS [N_TITLE][4] = '{
        // L
        '{60, 140, 302, 312},
        '{130, 140, 302, 342},
        // I
        '{60, 140, 352, 362},
        // N
        '{60, 140, 372, 382},
        '{60, 140, 412, 422},
        '{76, 92, 382, 392},
        '{92, 108, 392, 402},
        '{108, 124, 402, 412},
        // E
        '{60, 140, 432, 442},
        '{60, 70, 432, 472},
        '{130, 140, 432, 472},
        '{95, 105, 432, 462},
        // R
        '{60, 140, 522, 532},
        '{60, 70, 522, 542},
        '{70, 80, 542, 552},
        '{80, 100, 552, 562},
        '{100, 110, 542, 552},
        '{110, 120, 522, 542},
        '{120, 130, 542, 552},
        '{130, 140, 552, 562},
        // U
        '{60, 130, 572, 582},
        '{130, 140, 582, 612},
        '{60, 130, 612, 622},
        // S
        '{60, 70, 642, 662},
        '{70, 90, 632, 642},
        '{70, 80, 662, 672},
        '{90, 100, 642, 662},
        '{100, 130, 662, 672},
        '{130, 140, 642, 662},
        '{120, 130, 632, 642},
        // H
        '{60, 140, 682, 692},
        '{60, 140, 712, 722},
        '{95, 105, 682, 722}
    };

    // Start button border
    localparam logic [COORD_W-1:0] OUTLINE_RECTS [N_OUTLINE][4] = '{
        '{330, 335, 282, 742},
        '{330, 450, 282, 287},
        '{330, 450, 737, 742},
        '{445, 450, 282, 742}
    };

    localparam logic [COORD_W-1:0] LABEL_RECTS [N_LABEL][4] = '{
        // P
        '{350, 430, 422, 432},
        '{350, 360, 422, 442},
        '{360, 370, 442, 452},
        '{370, 390, 452, 462},
        '{390, 400, 442, 452},
        '{400, 410, 422, 442},
        '{410, 430, 422, 432},
        // L
        '{350, 430, 472, 482},
        '{420, 430, 472, 512},
        // A
        '{360, 430, 522, 532},
        '{360, 430, 552, 562},
        '{350, 360, 532, 552},
        '{380, 390, 522, 562},
        // Y
        '{350, 370, 572, 582},
        '{370, 380, 582, 592},
        '{380, 430, 592, 602},
        '{370, 380, 602, 612},
        '{350, 370, 612, 622}
    };

endpackage

`default_nettype wire

//--- hw/vga_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vga_if;

    logic [start_screen_pkg::COORD_W-1:0] hcount;
    logic [start_screen_pkg::COORD_W-1:0] vcount;
    logic                                 hsync;
    logic                                 vsync;
    logic                                 hblnk;
    logic                                 vblnk;

    // Producer side
    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk
    );

    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk
    );

endinterface

`default_nettype wire

//--- hw/frame_classify.sv
`timescale 1ns/1ps
`default_nettype none

module frame_classify (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [start_screen_pkg::COORD_W-1:0] hcount,
    input  logic [start_screen_pkg::COORD_W-1:0] vcount,
    input  logic                                 hsync,
    input  logic                                 vsync,
    input  logic                                 hblnk,
    input  logic                                 vblnk,
    vga_if.out                                   vga_out,
    output logic                                 is_blank,
    output logic                                 is_edge
);

    localparam int CW = start_screen_pkg::COORD_W;

    logic on_edge;

    // One pixel border of the visible area
    assign on_edge = (vcount == '0) ||
                     (vcount == CW'(start_screen_pkg::V_PIXELS - 1)) ||
                     (hcount == '0) ||
                     (hcount == CW'(start_screen_pkg::H_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            is_blank       <= 1'b0;
            is_edge        <= 1'b0;
        end else begin
            vga_out.hcount <= hcount;
            vga_out.vcount <= vcount;
            vga_out.hsync  <= hsync;
            vga_out.vsync  <= vsync;
            vga_out.hblnk  <= hblnk;
            vga_out.vblnk  <= vblnk;
            is_blank       <= hblnk || vblnk;
            is_edge        <= on_edge;
        end
    end

    // Timing generator must keep visible pixels on screen
    a_visible_range: assert property (@(posedge clk) disable iff (rst)
        !(hblnk || vblnk) |->
            (hcount < CW'(start_screen_pkg::H_PIXELS)) &&
            (vcount < CW'(start_screen_pkg::V_PIXELS)));

endmodule

`default_nettype wire

//--- hw/glyph_hit.sv
`timescale 1ns/1ps
`default_nettype none

module glyph_hit (
    input  logic clk,
    input  logic rst,
    vga_if.in    vga_in,
    input  logic is_blank,
    input  logic is_edge,
    vga_if.out   vga_out,
    output logic blank_d,
    output logic edge_d,
    output logic hit_title,
    output logic hit_outline,
    output logic hit_label
);

    localparam int CW = start_screen_pkg::COORD_W;

    logic [start_screen_pkg::N_TITLE-1:0]   title_v;
    logic [start_screen_pkg::N_OUTLINE-1:0] outline_v;
    logic [start_screen_pkg::N_LABEL-1:0]   label_v;

    // Strict inside test, bounds excluded
    function automatic logic in_rect(
        input logic [CW-1:0] h,
        input logic [CW-1:0] v,
        input logic [CW-1:0] top,
        input logic [CW-1:0] bottom,
        input logic [CW-1:0] left,
        input logic [CW-1:0] right
    );
        return (v > top) && (v < bottom) && (h > left) && (h < right);
    endfunction

    for (genvar i = 0; i < start_screen_pkg::N_TITLE; i++) begin : g_title
        assign title_v[i] = in_rect(vga_in.hcount, vga_in.vcount,
                                    start_screen_pkg::TITLE_RECTS[i][0],
                                    start_screen_pkg::TITLE_RECTS[i][1],
                                    start_screen_pkg::TITLE_RECTS[i][2],
                                    start_screen_pkg::TITLE_RECTS[i][3]);
    end

    for (genvar i = 0; i < start_screen_pkg::N_OUTLINE; i++) begin : g_outline
        assign outline_v[i] = in_rect(vga_in.hcount, vga_in.vcount,
                                      start_screen_pkg::OUTLINE_RECTS[i][0],
                                      start_screen_pkg::OUTLINE_RECTS[i][1],
                                      start_screen_pkg::OUTLINE_RECTS[i][2],
                                      start_screen_pkg::OUTLINE_RECTS[i][3]);
    end

    for (genvar i = 0; i < start_screen_pkg::N_LABEL; i++) begin : g_label
        assign label_v[i] = in_rect(vga_in.hcount, vga_in.vcount,
                                    start_screen_pkg::LABEL_RECTS[i][0],
                                    start_screen_pkg::LABEL_RECTS[i][1],
                                    start_screen_pkg::LABEL_RECTS[i][2],
                                    start_screen_pkg::LABEL_RECTS[i][3]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            blank_d        <= 1'b0;
            edge_d         <= 1'b0;
            hit_title      <= 1'b0;
            hit_outline    <= 1'b0;
            hit_label      <= 1'b0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            blank_d        <= is_blank;
            edge_d         <= is_edge;
            hit_title      <= |title_v;
            hit_outline    <= |outline_v;
            hit_label      <= |label_v;
        end
    end

    // Label sits fully inside the button border
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(hit_outline && hit_label));

endmodule

`default_nettype wire

//--- hw/color_mux.sv
`timescale 1ns/1ps
`default_nettype none

module color_mux #(
    parameter logic [start_screen_pkg::RGB_W-1:0] TITLE_COLOR = 12'hf0f,
    parameter logic [start_screen_pkg::RGB_W-1:0] LABEL_COLOR = 12'hf0f
) (
    input  logic                               clk,
    input  logic                               rst,
    vga_if.in                                  vga_in,
    input  logic                               blank_d,
    input  logic                               edge_d,
    input  logic                               hit_title,
    input  logic                               hit_outline,
    input  logic                               hit_label,
    vga_if.out                                 vga_out,
    output logic [start_screen_pkg::RGB_W-1:0] rgb
);

    logic [start_screen_pkg::RGB_W-1:0] rgb_nxt;

    // Blanking wins over everything, then frame, then glyphs
    always_comb begin
        if (blank_d)
            rgb_nxt = start_screen_pkg::BLACK;
        else if (edge_d)
            rgb_nxt = start_screen_pkg::FRAME_COLOR;
        else if (hit_title)
            rgb_nxt = TITLE_COLOR;
        else if (hit_outline)
            rgb_nxt = start_screen_pkg::FRAME_COLOR;
        else if (hit_label)
            rgb_nxt = LABEL_COLOR;
        else
            rgb_nxt = start_screen_pkg::BLACK;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            rgb            <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            rgb            <= rgb_nxt;
        end
    end

    // Blank flag from stage one must still line up with the delayed timing
    a_black_in_blank: assert property (@(posedge clk) disable iff (rst)
        (vga_out.hblnk || vga_out.vblnk) |-> (rgb == start_screen_pkg::BLACK));

endmodule

`default_nettype wire

//--- hw/start_screen_top.sv
`timescale 1ns/1ps
`default_nettype none

module start_screen_top #(
    parameter logic [start_screen_pkg::RGB_W-1:0] TITLE_COLOR = 12'hf0f,
    parameter logic [start_screen_pkg::RGB_W-1:0] LABEL_COLOR = 12'hf0f
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [start_screen_pkg::COORD_W-1:0] hcount,
    input  logic [start_screen_pkg::COORD_W-1:0] vcount,
    input  logic                                 hsync,
    input  logic                                 vsync,
    input  logic                                 hblnk,
    input  logic                                 vblnk,
    output logic [start_screen_pkg::COORD_W-1:0] hcount_out,
    output logic [start_screen_pkg::COORD_W-1:0] vcount_out,
    output logic                                 hsync_out,
    output logic                                 vsync_out,
    output logic                                 hblnk_out,
    output logic                                 vblnk_out,
    output logic [start_screen_pkg::RGB_W-1:0]   rgb
);

    vga_if s1 ();
    vga_if s2 ();
    vga_if s3 ();

    logic is_blank;
    logic is_edge;
    logic blank_d;
    logic edge_d;
    logic hit_title;
    logic hit_outline;
    logic hit_label;

    frame_classify u_frame_classify (
        .clk      (clk),
        .rst      (rst),
        .hcount   (hcount),
        .vcount   (vcount),
        .hsync    (hsync),
        .vsync    (vsync),
        .hblnk    (hblnk),
        .vblnk    (vblnk),
        .vga_out  (s1.out),
        .is_blank (is_blank),
        .is_edge  (is_edge)
    );

    glyph_hit u_glyph_hit (
        .clk         (clk),
        .rst         (rst),
        .vga_in      (s1.in),
        .is_blank    (is_blank),
        .is_edge     (is_edge),
        .vga_out     (s2.out),
        .blank_d     (blank_d),
        .edge_d      (edge_d),
        .hit_title   (hit_title),
        .hit_outline (hit_outline),
        .hit_label   (hit_label)
    );

    color_mux #(
        .TITLE_COLOR (TITLE_COLOR),
        .LABEL_COLOR (LABEL_COLOR)
    ) u_color_mux (
        .clk         (clk),
        .rst         (rst),
        .vga_in      (s2.in),
        .blank_d     (blank_d),
        .edge_d      (edge_d),
        .hit_title   (hit_title),
        .hit_outline (hit_outline),
        .hit_label   (hit_label),
        .vga_out     (s3.out),
        .rgb         (rgb)
    );

    assign hcount_out = s3.hcount;
    assign vcount_out = s3.vcount;
    assign hsync_out  = s3.hsync;
    assign vsync_out  = s3.vsync;
    assign hblnk_out  = s3.hblnk;
    assign vblnk_out  = s3.vblnk;

endmodule

`default_nettype wire

//--- verification/start_screen_tests.svh
`ifndef START_SCREEN_TESTS_SVH
`define START_SCREEN_TESTS_SVH
`default_nettype none

// Inputs change 1 ns after the rising edge, outputs are read at the same point
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic drive_pixel(input int row, input int col, input logic hs, input logic vs,
                           input logic hb, input logic vb);
    vcount = CW'(row);
    hcount = CW'(col);
    hsync  = hs;
    vsync  = vs;
    hblnk  = hb;
    vblnk  = vb;
endtask

task automatic check_single_pixel(input int row, input int col, input logic hb, input logic vb,
                                  input logic [start_screen_pkg::RGB_W-1:0] exp_rgb,
                                  input string name);
    logic hs;
    logic vs;
    hs = 1'($urandom);
    vs = 1'($urandom);
    drive_pixel(row, col, hs, vs, hb, vb);
    repeat (3) next_cycle();
    check_rgb(rgb, exp_rgb, name);
    check_timing(CW'(col), CW'(row), hs, vs, hb, vb);
endtask

task automatic test_reset();
    rst = 1'b1;
    drive_pixel(100, 307, 1'b1, 1'b1, 1'b0, 1'b0);
    repeat (4) begin
        next_cycle();
        check_rgb(rgb, start_screen_pkg::BLACK, "rgb during reset");
        check_timing('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    rst = 1'b0;
    // Pipeline still holds reset values until the pixel reaches the last stage
    repeat (2) begin
        next_cycle();
        check_rgb(rgb, start_screen_pkg::BLACK, "rgb after reset release");
        check_timing('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    next_cycle();
    check_rgb(rgb, TITLE_COLOR, "rgb first pixel after reset");
    check_timing(CW'(307), CW'(100), 1'b1, 1'b1, 1'b0, 1'b0);
endtask

task automatic test_blank_frame();
    check_single_pixel(0, 0, 1'b1, 1'b0, start_screen_pkg::BLACK, "rgb hblnk corner");
    check_single_pixel(800, 300, 1'b0, 1'b1, start_screen_pkg::BLACK, "rgb vblnk");
    check_single_pixel(0, 500, 1'b0, 1'b0, start_screen_pkg::FRAME_COLOR, "rgb top edge");
    check_single_pixel(767, 500, 1'b0, 1'b0, start_screen_pkg::FRAME_COLOR, "rgb bottom edge");
    check_single_pixel(400, 0, 1'b0, 1'b0, start_screen_pkg::FRAME_COLOR, "rgb left edge");
    check_single_pixel(400, 1023, 1'b0, 1'b0, start_screen_pkg::FRAME_COLOR, "rgb right edge");
endtask

task automatic test_title();
    check_single_pixel(100, 307, 1'b0, 1'b0, TITLE_COLOR, "rgb title first stem");
    check_single_pixel(100, 717, 1'b0, 1'b0, TITLE_COLOR, "rgb title last stem");
    // Bounds are exclusive
    check_single_pixel(60, 307, 1'b0, 1'b0, start_screen_pkg::BLACK, "rgb title bound");
endtask

task automatic test_button();
    check_single_pixel(332, 500, 1'b0, 1'b0, start_screen_pkg::FRAME_COLOR, "rgb outline top");
    check_single_pixel(400, 285, 1'b0, 1'b0, start_screen_pkg::FRAME_COLOR, "rgb outline left");
    check_single_pixel(400, 427, 1'b0, 1'b0, LABEL_COLOR, "rgb label first");
    check_single_pixel(420, 597, 1'b0, 1'b0, LABEL_COLOR, "rgb label last");
    check_single_pixel(400, 500, 1'b0, 1'b0, start_screen_pkg::BLACK, "rgb inside button");
endtask

task automatic test_stream();
    int d_row [10] = '{100, 100, 60, 332, 400, 400, 420, 400, 0, 767};
    int d_col [10] = '{307, 717, 307, 500, 285, 427, 597, 500, 0, 500};
    logic d_hb [10] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    logic [start_screen_pkg::RGB_W-1:0] d_rgb [10];
    int row [20];
    int col [20];
    logic hs [20];
    logic vs [20];
    logic hb [20];
    logic vb [20];
    logic [start_screen_pkg::RGB_W-1:0] exp_rgb [20];
    // Corner pixel in hblnk stays black over the frame
    d_rgb = '{TITLE_COLOR, TITLE_COLOR, start_screen_pkg::BLACK,
              start_screen_pkg::FRAME_COLOR, start_screen_pkg::FRAME_COLOR,
              LABEL_COLOR, LABEL_COLOR, start_screen_pkg::BLACK,
              start_screen_pkg::BLACK, start_screen_pkg::FRAME_COLOR};
    // Even slots random, empty area between title and button, random vblnk
    for (int i = 0; i < 20; i++) begin
        hs[i] = 1'($urandom);
        vs[i] = 1'($urandom);
        if (i % 2 == 1) begin
            row[i]     = d_row[i / 2];
            col[i]     = d_col[i / 2];
            hb[i]      = d_hb[i / 2];
            vb[i]      = 1'b0;
            exp_rgb[i] = d_rgb[i / 2];
        end else begin
            row[i]     = 210 + int'($urandom % 111);
            col[i]     = 10 + int'($urandom % 991);
            hb[i]      = 1'b0;
            vb[i]      = 1'($urandom);
            exp_rgb[i] = start_screen_pkg::BLACK;
        end
    end
    for (int i = 0; i < 23; i++) begin
        if (i < 20)
            drive_pixel(row[i], col[i], hs[i], vs[i], hb[i], vb[i]);
        if (i >= 3) begin
            check_rgb(rgb, exp_rgb[i - 3], $sformatf("rgb stream pixel %0d", i - 3));
            check_timing(CW'(col[i - 3]), CW'(row[i - 3]), hs[i - 3], vs[i - 3],
                         hb[i - 3], vb[i - 3]);
        end
        next_cycle();
    end
endtask

`default_nettype wire
`endif

//--- verification/tb_start_screen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_start_screen;

    localparam int CW = start_screen_pkg::COORD_W;
    localparam int CLK_PERIOD = 20;
    // Whole test sequence stays under 500 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [start_screen_pkg::RGB_W-1:0] TITLE_COLOR = 12'hf0f;
    localparam logic [start_screen_pkg::RGB_W-1:0] LABEL_COLOR = 12'hf0f;

    logic                             clk = 1'b0;
    logic                             rst;
    logic [CW-1:0]                    hcount;
    logic [CW-1:0]                    vcount;
    logic                             hsync;
    logic                             vsync;
    logic                             hblnk;
    logic                             vblnk;
    logic [CW-1:0]                    hcount_out;
    logic [CW-1:0]                    vcount_out;
    logic                             hsync_out;
    logic                             vsync_out;
    logic                             hblnk_out;
    logic                             vblnk_out;
    logic [start_screen_pkg::RGB_W-1:0] rgb;

    int cycle_count = 0;
    int check_count = 0;

    start_screen_top dut (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb        (rgb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(
        input logic [start_screen_pkg::RGB_W-1:0] actual,
        input logic [start_screen_pkg::RGB_W-1:0] expected,
        input string name
    );
        check_count++;
        if (actual !== expected)
            stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
    endtask

    task automatic check_timing(
        input logic [CW-1:0] exp_h,
        input logic [CW-1:0] exp_v,
        input logic          exp_hs,
        input logic          exp_vs,
        input logic          exp_hb,
        input logic          exp_vb
    );
        check_count++;
        if (hcount_out !== exp_h)
            stop_on_error($sformatf("Mismatch hcount_out: got %h, expected %h",
                                    hcount_out, exp_h));
        if (vcount_out !== exp_v)
            stop_on_error($sformatf("Mismatch vcount_out: got %h, expected %h",
                                    vcount_out, exp_v));
        if (hsync_out !== exp_hs)
            stop_on_error($sformatf("Mismatch hsync_out: got %h, expected %h", hsync_out, exp_hs));
        if (vsync_out !== exp_vs)
            stop_on_error($sformatf("Mismatch vsync_out: got %h, expected %h", vsync_out, exp_vs));
        if (hblnk_out !== exp_hb)
            stop_on_error($sformatf("Mismatch hblnk_out: got %h, expected %h", hblnk_out, exp_hb));
        if (vblnk_out !== exp_vb)
            stop_on_error($sformatf("Mismatch vblnk_out: got %h, expected %h", vblnk_out, exp_vb));
    endtask

    initial begin
        rst    = 1'b1;
        hcount = '0;
        vcount = '0;
        hsync  = 1'b0;
        vsync  = 1'b0;
        hblnk  = 1'b0;
        vblnk  = 1'b0;
        void'($urandom(32'h6808c961));
        test_reset();
        test_blank_frame();
        test_title();
        test_button();
        test_stream();
        if (check_count > 0) begin
            $display("TEST PASS");
        end else begin
            $display("No checks were run");
            $display("TEST FAIL");
        end
        $finish;
    end

`include "start_screen_tests.svh"

endmodule

`default_nettype wire

//--- src.f
+incdir+verification
hw/start_screen_pkg.sv
hw/vga_if.sv
hw/frame_classify.sv
hw/glyph_hit.sv
hw/color_mux.sv
hw/start_screen_top.sv
verification/tb_start_screen.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the start screen testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_start_screen -Mdir "$BUILD_DIR" -o sim_start_screen
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_start_screen" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
exit 1
